/* compile.f */
design/engine_ctrl_pkg.sv
design/cmd_fifo.sv
design/axi_write_capture.sv
design/board_regs.sv
design/engine_ctrl_top.sv
sim/tb_clock_gen.sv
sim/tb_engine_ctrl.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the engine control testbench with Verilator and runs it

cd "$(dirname "$0")"
status=$?
if [ $status -ne 0 ]; then
   echo "Cannot enter the project directory"
   exit 1
fi

verilator --binary --timing --assert -Wno-fatal -f compile.f \
   --top-module tb_engine_ctrl -o tb_engine_ctrl > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
   cat build.log
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/tb_engine_ctrl > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "TEST RESULT: FAIL" sim.log; then
   exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
   echo "No result line found in sim.log"
   exit 1
fi
exit 0

/* sim/tb_engine_ctrl.sv */
`timescale 1ns/1ps

module tb_engine_ctrl
   import engine_ctrl_pkg::*;
;

   localparam int TIMEOUT = 200;

   logic clk, rst_n;
   logic [AXI_ADDR_WIDTH-1:0] awaddr, araddr;
   logic awvalid, awready, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rvalid, rready;
   logic [DATA_WIDTH-1:0] wdata, rdata;
   logic engine_idle, moves_ready, move_ready;
   logic [MOVE_INDEX_WIDTH-1:0] move_count, move_index;
   logic [EVAL_WIDTH-1:0] move_eval;
   logic new_board_valid, clear_moves, soft_reset, white_to_move;
   logic [BOARD_WIDTH-1:0] new_board;
   logic [3:0] castle_mask, en_passant_col;
   logic [HALF_MOVE_WIDTH-1:0] half_move;

   // Expected register state
   logic m_nbv = 0, m_clear = 0, m_soft = 0, m_white = 0;
   logic [3:0] m_castle = '0, m_ep = '0;
   logic [7:0] m_half = '0, m_move_index = '0;
   logic [BOARD_WIDTH-1:0] m_board = '0;

   reg_index_t aw_index_q[$];
   logic [DATA_WIDTH-1:0] w_data_q[$], ar_exp_q[$];
   logic [DATA_WIDTH-1:0] exp_rd_head = '0;   // Expected data of oldest read
   int aw_count = 0, b_count = 0, ar_count = 0, r_count = 0;
   int check_errors = 0, timeout_errors = 0;
   logic b_hold = 0, ar_full_expect = 0, end_phase = 0;
   logic [15:0] lfsr = 16'd83;

   tb_clock_gen clock_gen (.clk(clk), .rst_n(rst_n));

   engine_ctrl_top UUT (.*);

   function automatic logic [DATA_WIDTH-1:0] random_bits(input int count);
      logic [DATA_WIDTH-1:0] v;
      v = '0;
      for (int i = 0; i < count; i++)
      begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);   // Galois step
         v = {v[DATA_WIDTH-2:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic void apply_write(input reg_index_t index, input logic [31:0] data);
      int rank;
      rank = int'(index) - REG_BOARD_BASE;
      if (index == REG_CONTROL)
      begin
         m_nbv   = data[CTRL_NEW_BOARD_BIT];
         m_clear = data[CTRL_CLEAR_MOVES_BIT];
         m_soft  = data[CTRL_SOFT_RESET_BIT];
      end
      else if (index == REG_MOVE_INDEX) m_move_index = data[7:0];
      else if (index == REG_POSITION) {m_white, m_castle, m_ep} = data[8:0];
      else if (index == REG_HALF_MOVE) m_half = data[7:0];
      else if (rank >= 0 && rank < BOARD_RANKS) m_board[rank*SIDE_WIDTH +: SIDE_WIDTH] = data;
   endfunction

   function automatic logic [DATA_WIDTH-1:0] expected_read(input reg_index_t index);
      logic [DATA_WIDTH-1:0] v;
      int rank;
      v = '0;   // Unmapped words read as zero
      rank = int'(index) - REG_BOARD_BASE;
      if (index == REG_CONTROL)
      begin
         v[CTRL_NEW_BOARD_BIT]   = m_nbv;
         v[CTRL_CLEAR_MOVES_BIT] = m_clear;
         v[CTRL_MOVES_READY_BIT] = moves_ready;
         v[CTRL_MOVE_READY_BIT]  = move_ready;
         v[CTRL_IDLE_BIT]        = engine_idle;
         v[CTRL_SOFT_RESET_BIT]  = m_soft;
      end
      else if (index == REG_MOVE_INDEX) v[7:0] = m_move_index;
      else if (index == REG_POSITION) v[8:0] = {m_white, m_castle, m_ep};
      else if (index == REG_HALF_MOVE) v[7:0] = m_half;
      else if (index == REG_MOVE_EVAL) v = move_eval[23] ? {8'hFF, move_eval} : {8'h00, move_eval};
      else if (index == REG_MOVE_COUNT) v[7:0] = move_count;
      else if (rank >= 0 && rank < BOARD_RANKS) v = m_board[rank*SIDE_WIDTH +: SIDE_WIDTH];
      return v;
   endfunction

   task automatic count_failure(input string msg);
      check_errors++;
      $display("CHECK FAILED at %0t: %s", $time, msg);
   endtask

   // Bus monitor keeps the expected state in step with handshakes
   always @(posedge clk)
   begin
      if (awvalid && awready)
      begin
         aw_index_q.push_back(awaddr[REG_INDEX_WIDTH+1:2]);
         aw_count++;
      end
      if (wvalid && wready) w_data_q.push_back(wdata);
      if (bvalid && bready)
      begin
         b_count++;
         if (aw_index_q.size() > 0 && w_data_q.size() > 0)
            apply_write(aw_index_q.pop_front(), w_data_q.pop_front());
      end
      if (arvalid && arready)
      begin
         ar_exp_q.push_back(expected_read(araddr[REG_INDEX_WIDTH+1:2]));
         ar_count++;
      end
      if (rvalid && rready)
      begin
         r_count++;
         if (ar_exp_q.size() > 0) void'(ar_exp_q.pop_front());
      end
      exp_rd_head = (ar_exp_q.size() > 0) ? ar_exp_q[0] : '0;
   end

   a_reset_quiet: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |->
      !bvalid && !rvalid && !new_board_valid && !clear_moves && !soft_reset &&
      move_index == 0 && new_board == 0)
      else count_failure("outputs not idle around reset");

   // No write is in flight once bvalid is low
   a_outputs_match: assert property (@(posedge clk) !bvalid |->
      new_board_valid == m_nbv && clear_moves == m_clear && soft_reset == m_soft &&
      move_index == m_move_index && white_to_move == m_white && castle_mask == m_castle &&
      en_passant_col == m_ep && half_move == m_half && new_board == m_board)
      else count_failure("engine outputs differ from written registers");

   a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid && rready |-> rdata == exp_rd_head)
      else count_failure($sformatf("rdata %08h, expected %08h", rdata, exp_rd_head));

   a_single_b: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid && bready |-> b_count < aw_count)
      else count_failure("write response without an accepted write");

   a_b_stall: assert property (@(posedge clk) disable iff (!rst_n)
      b_hold && bvalid |-> !awready && !wready)
      else count_failure("AW or W accepted while a response is pending");

   a_ar_full: assert property (@(posedge clk) disable iff (!rst_n)
      ar_full_expect |-> !arready)
      else count_failure("arready high with the read queue full");

   a_all_done: assert property (@(posedge clk)
      end_phase |-> b_count == aw_count && r_count == ar_count)
      else count_failure("responses missing at the end of the run");

   task automatic send_write(input int index, input logic [31:0] data);
      int cycles;
      logic aw_done, w_done;
      logic aw_go, w_go;
      aw_done = 0;
      w_done  = 0;
      @(negedge clk);
      awaddr  = AXI_ADDR_WIDTH'({reg_index_t'(index), 2'b00});
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      for (cycles = 0; cycles < TIMEOUT && !(aw_done && w_done); cycles++)
      begin
         aw_go = awvalid && awready;   // Sampled before the edge
         w_go  = wvalid && wready;
         @(posedge clk);
         aw_done = aw_done || aw_go;
         w_done  = w_done || w_go;
         @(negedge clk);
         awvalid = !aw_done;
         wvalid  = !w_done;
      end
      if (!(aw_done && w_done))
      begin
         $display("Timeout: write beats to index %0d were never accepted", index);
         timeout_errors++;
         awvalid = 1'b0;
         wvalid  = 1'b0;
      end
   endtask

   task automatic wait_write_responses();
      int cycles;
      for (cycles = 0; cycles < TIMEOUT && b_count != aw_count; cycles++) @(negedge clk);
      if (b_count != aw_count)
      begin
         $display("Timeout: write response never arrived");
         timeout_errors++;
      end
   endtask

   task automatic write_reg(input int index, input logic [31:0] data);
      send_write(index, data);
      wait_write_responses();
   endtask

   task automatic send_read_addr(input int index);
      int cycles;
      logic done;
      logic go;
      done = 0;
      @(negedge clk);
      araddr  = AXI_ADDR_WIDTH'({reg_index_t'(index), 2'b00});
      arvalid = 1'b1;
      for (cycles = 0; cycles < TIMEOUT && !done; cycles++)
      begin
         go = arready;
         @(posedge clk);
         done = go;
         @(negedge clk);
      end
      arvalid = 1'b0;
      if (!done)
      begin
         $display("Timeout: read address %0d was never accepted", index);
         timeout_errors++;
      end
   endtask

   task automatic wait_read_data();
      int cycles;
      for (cycles = 0; cycles < TIMEOUT && r_count != ar_count; cycles++) @(negedge clk);
      if (r_count != ar_count)
      begin
         $display("Timeout: read data never arrived");
         timeout_errors++;
      end
   endtask

   task automatic read_reg(input int index);
      send_read_addr(index);
      wait_read_data();
   endtask

   initial
   begin
      logic [DATA_WIDTH-1:0] value;
      int cycles;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wvalid = 1'b0;
      bready = 1'b1;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b1;
      engine_idle = 1'b0;
      moves_ready = 1'b0;
      move_ready = 1'b0;
      move_count = '0;
      move_eval = '0;
      for (cycles = 0; cycles < TIMEOUT && !rst_n; cycles++) @(negedge clk);
      if (!rst_n)
      begin
         $display("Timeout: reset was never released");
         timeout_errors++;
      end

      repeat (4)
      begin
         write_reg(REG_MOVE_INDEX, random_bits(MOVE_INDEX_WIDTH));
         read_reg(REG_MOVE_INDEX);
         write_reg(REG_POSITION, random_bits(9));   // Side, castle and en passant
         read_reg(REG_POSITION);
         write_reg(REG_HALF_MOVE, random_bits(HALF_MOVE_WIDTH));
         read_reg(REG_HALF_MOVE);
      end

      for (int r = 0; r < BOARD_RANKS; r++) write_reg(REG_BOARD_BASE + r, random_bits(32));
      for (int r = 0; r < BOARD_RANKS; r++) read_reg(REG_BOARD_BASE + r);
      repeat (4)
      begin
         value = random_bits(3);
         write_reg(REG_CONTROL, {value[2], 29'b0, value[1:0]});
         read_reg(REG_CONTROL);
      end

      repeat (4)
      begin
         @(negedge clk);
         value = random_bits(3);
         {engine_idle, moves_ready, move_ready} = value[2:0];
         move_count = MOVE_INDEX_WIDTH'(random_bits(MOVE_INDEX_WIDTH));
         move_eval = EVAL_WIDTH'(random_bits(EVAL_WIDTH));
         read_reg(REG_CONTROL);
         read_reg(REG_MOVE_COUNT);
         read_reg(REG_MOVE_EVAL);
      end

      @(negedge clk);
      bready = 1'b0;
      b_hold = 1'b1;
      fork
         repeat (3) send_write(REG_HALF_MOVE, random_bits(HALF_MOVE_WIDTH));
         begin
            repeat (12) @(negedge clk);   // Let AW and W stall first
            b_hold = 1'b0;
            bready = 1'b1;
         end
      join
      wait_write_responses();
      read_reg(REG_HALF_MOVE);

      @(negedge clk);
      rready = 1'b0;
      for (int r = 0; r < 5; r++) send_read_addr(REG_BOARD_BASE + r);
      ar_full_expect = 1'b1;
      repeat (3) @(negedge clk);
      ar_full_expect = 1'b0;
      rready = 1'b1;
      wait_read_data();

      write_reg(600, random_bits(32));
      read_reg(600);

      end_phase = 1'b1;
      repeat (2) @(negedge clk);
      $display("Failed checks: %0d, timeouts: %0d", check_errors, timeout_errors);
      if (check_errors == 0 && timeout_errors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
(
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // 10 ns period
   end

   initial
   begin
      rst_n = 1'b0;
      repeat (16) @(negedge clk);
      rst_n = 1'b1;   // Released away from the rising edge
   end

endmodule

/* design/engine_ctrl_top.sv */
`timescale 1ns/1ps

module engine_ctrl_top
   import engine_ctrl_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic [AXI_ADDR_WIDTH-1:0]     awaddr,
   input  logic                          awvalid,
   output logic                          awready,
   input  logic [DATA_WIDTH-1:0]         wdata,
   input  logic                          wvalid,
   output logic                          wready,
   output logic                          bvalid,
   input  logic                          bready,
   input  logic [AXI_ADDR_WIDTH-1:0]     araddr,
   input  logic                          arvalid,
   output logic                          arready,
   output logic [DATA_WIDTH-1:0]         rdata,
   output logic                          rvalid,
   input  logic                          rready,
   input  logic                          engine_idle,
   input  logic                          moves_ready,
   input  logic                          move_ready,
   input  logic [MOVE_INDEX_WIDTH-1:0]   move_count,
   input  logic signed [EVAL_WIDTH-1:0]  move_eval,
   output logic                          new_board_valid,
   output logic                          clear_moves,
   output logic                          soft_reset,
   output logic [BOARD_WIDTH-1:0]        new_board,
   output logic                          white_to_move,
   output logic [3:0]                    castle_mask,
   output logic [3:0]                    en_passant_col,
   output logic [HALF_MOVE_WIDTH-1:0]    half_move,
   output logic [MOVE_INDEX_WIDTH-1:0]   move_index
);

   wr_cmd_t    cap_cmd;
   logic       cap_valid;
   logic       cap_ready;
   wr_cmd_t    wq_cmd;
   logic       wq_valid;
   logic       wq_ready;
   reg_index_t ar_index;
   reg_index_t rq_index;
   logic       rq_valid;
   logic       rq_ready;

   assign ar_index = araddr[REG_INDEX_WIDTH+1:2];

   axi_write_capture write_capture (
      .clk       (clk),
      .rst_n     (rst_n),
      .awaddr    (awaddr),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wvalid    (wvalid),
      .wready    (wready),
      .bvalid    (bvalid),
      .bready    (bready),
      .cmd_valid (cap_valid),
      .cmd       (cap_cmd),
      .cmd_ready (cap_ready)
   );

   cmd_fifo #(.payload_t(wr_cmd_t)) write_queue (
      .clk        (clk),
      .rst_n      (rst_n),
      .push_valid (cap_valid),
      .push_data  (cap_cmd),
      .push_ready (cap_ready),
      .pop_valid  (wq_valid),
      .pop_data   (wq_cmd),
      .pop_ready  (wq_ready)
   );

   cmd_fifo #(.payload_t(reg_index_t)) read_queue (
      .clk        (clk),
      .rst_n      (rst_n),
      .push_valid (arvalid),
      .push_data  (ar_index),
      .push_ready (arready),
      .pop_valid  (rq_valid),
      .pop_data   (rq_index),
      .pop_ready  (rq_ready)
   );

   board_regs regs (
      .clk             (clk),
      .rst_n           (rst_n),
      .wr_valid        (wq_valid),
      .wr_cmd          (wq_cmd),
      .wr_ready        (wq_ready),
      .rd_valid        (rq_valid),
      .rd_index        (rq_index),
      .rd_ready        (rq_ready),
      .rdata           (rdata),
      .rvalid          (rvalid),
      .rready          (rready),
      .engine_idle     (engine_idle),
      .moves_ready     (moves_ready),
      .move_ready      (move_ready),
      .move_count      (move_count),
      .move_eval       (move_eval),
      .new_board_valid (new_board_valid),
      .clear_moves     (clear_moves),
      .soft_reset      (soft_reset),
      .new_board       (new_board),
      .white_to_move   (white_to_move),
      .castle_mask     (castle_mask),
      .en_passant_col  (en_passant_col),
      .half_move       (half_move),
      .move_index      (move_index)
   );

endmodule

/* design/board_regs.sv */
`timescale 1ns/1ps

module board_regs
   import engine_ctrl_pkg::*;
(
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          wr_valid,
   input  wr_cmd_t                       wr_cmd,
   output logic                          wr_ready,
   input  logic                          rd_valid,
   input  reg_index_t                    rd_index,
   output logic                          rd_ready,
   output logic [DATA_WIDTH-1:0]         rdata,
   output logic                          rvalid,
   input  logic                          rready,
   input  logic                          engine_idle,
   input  logic                          moves_ready,
   input  logic                          move_ready,
   input  logic [MOVE_INDEX_WIDTH-1:0]   move_count,
   input  logic signed [EVAL_WIDTH-1:0]  move_eval,
   output logic                          new_board_valid,
   output logic                          clear_moves,
   output logic                          soft_reset,
   output logic [BOARD_WIDTH-1:0]        new_board,
   output logic                          white_to_move,
   output logic [3:0]                    castle_mask,
   output logic [3:0]                    en_passant_col,
   output logic [HALF_MOVE_WIDTH-1:0]    half_move,
   output logic [MOVE_INDEX_WIDTH-1:0]   move_index
);

   logic                           wr_fire;
   logic                           rd_fire;
   logic                           wr_is_board;
   logic                           rd_is_board;
   logic [$clog2(BOARD_RANKS)-1:0] wr_rank;
   logic [$clog2(BOARD_RANKS)-1:0] rd_rank;
   logic [DATA_WIDTH-1:0]          rd_word;

   assign wr_ready = 1'b1;   // Every write applies in one cycle
   assign rd_ready = !wr_valid && (!rvalid || rready);   // Writes first

   assign wr_fire = wr_valid && wr_ready;
   assign rd_fire = rd_valid && rd_ready;

   // Board base is rank aligned
   assign wr_is_board = (wr_cmd.index >= REG_BOARD_BASE) &&
                        (wr_cmd.index < REG_BOARD_BASE + BOARD_RANKS);
   assign rd_is_board = (rd_index >= REG_BOARD_BASE) &&
                        (rd_index < REG_BOARD_BASE + BOARD_RANKS);
   assign wr_rank = wr_cmd.index[$clog2(BOARD_RANKS)-1:0];
   assign rd_rank = rd_index[$clog2(BOARD_RANKS)-1:0];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         new_board_valid <= 1'b0;
         clear_moves     <= 1'b0;
         soft_reset      <= 1'b0;
         move_index      <= '0;
         white_to_move   <= 1'b0;
         castle_mask     <= '0;
         en_passant_col  <= '0;
         half_move       <= '0;
         new_board       <= '0;
      end
      else if (wr_fire)
      begin
         case (wr_cmd.index)
            REG_CONTROL:
            begin
               new_board_valid <= wr_cmd.data[CTRL_NEW_BOARD_BIT];
               clear_moves     <= wr_cmd.data[CTRL_CLEAR_MOVES_BIT];
               soft_reset      <= wr_cmd.data[CTRL_SOFT_RESET_BIT];
            end
            REG_MOVE_INDEX: move_index <= wr_cmd.data[MOVE_INDEX_WIDTH-1:0];
            REG_POSITION:
            begin
               {white_to_move, castle_mask, en_passant_col} <= wr_cmd.data[8:0];
            end
            REG_HALF_MOVE:  half_move <= wr_cmd.data[HALF_MOVE_WIDTH-1:0];
            default:
            begin
               if (wr_is_board)
               begin
                  new_board[wr_rank*SIDE_WIDTH +: SIDE_WIDTH] <= wr_cmd.data[SIDE_WIDTH-1:0];
               end
            end
         endcase
      end
   end

   always_comb
   begin
      rd_word = '0;   // Unmapped reads give zero
      case (rd_index)
         REG_CONTROL:
         begin
            rd_word[CTRL_NEW_BOARD_BIT]   = new_board_valid;
            rd_word[CTRL_CLEAR_MOVES_BIT] = clear_moves;
            rd_word[CTRL_MOVES_READY_BIT] = moves_ready;
            rd_word[CTRL_MOVE_READY_BIT]  = move_ready;
            rd_word[CTRL_IDLE_BIT]        = engine_idle;
            rd_word[CTRL_SOFT_RESET_BIT]  = soft_reset;
         end
         REG_MOVE_INDEX: rd_word = DATA_WIDTH'(move_index);
         REG_POSITION:   rd_word = DATA_WIDTH'({white_to_move, castle_mask, en_passant_col});
         REG_HALF_MOVE:  rd_word = DATA_WIDTH'(half_move);
         REG_MOVE_EVAL:
         begin
            rd_word = {{(DATA_WIDTH - EVAL_WIDTH){move_eval[EVAL_WIDTH-1]}}, move_eval};
         end
         REG_MOVE_COUNT: rd_word = DATA_WIDTH'(move_count);
         default:
         begin
            if (rd_is_board)
            begin
               rd_word[SIDE_WIDTH-1:0] = new_board[rd_rank*SIDE_WIDTH +: SIDE_WIDTH];
            end
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rvalid <= 1'b0;
         rdata  <= '0;
      end
      else if (rd_fire)
      begin
         rvalid <= 1'b1;
         rdata  <= rd_word;
      end
      else if (rready)
      begin
         rvalid <= 1'b0;
      end
   end

   // A stalled response is neither replaced nor dropped
   a_r_stall: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid && !rready |-> !rd_fire ##1 rvalid && $stable(rdata));

endmodule

/* design/axi_write_capture.sv */
`timescale 1ns/1ps

module axi_write_capture
   import engine_ctrl_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
   input  logic                      awvalid,
   output logic                      awready,
   input  logic [DATA_WIDTH-1:0]     wdata,
   input  logic                      wvalid,
   output logic                      wready,
   output logic                      bvalid,
   input  logic                      bready,
   output logic                      cmd_valid,
   output wr_cmd_t                   cmd,
   input  logic                      cmd_ready
);

   logic                  bus_open;   // Set one cycle after reset release
   logic                  aw_held;
   logic                  w_held;
   reg_index_t            addr_q;
   logic [DATA_WIDTH-1:0] data_q;
   logic                  aw_fire;
   logic                  w_fire;
   logic                  cmd_fire;

   // A channel stalls once its beat is held or a response is pending
   assign awready = bus_open && !aw_held && !bvalid;
   assign wready  = bus_open && !w_held && !bvalid;

   assign aw_fire  = awvalid && awready;
   assign w_fire   = wvalid && wready;

   assign cmd_valid  = aw_held && w_held;
   assign cmd.index  = addr_q;
   assign cmd.data   = data_q;
   assign cmd_fire   = cmd_valid && cmd_ready;

   always_ff @(posedge clk)
   begin
      if (aw_fire)
      begin
         addr_q <= awaddr[REG_INDEX_WIDTH+1:2];   // Word index
      end
      if (w_fire)
      begin
         data_q <= wdata;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         bus_open <= 1'b0;
         aw_held  <= 1'b0;
         w_held   <= 1'b0;
         bvalid   <= 1'b0;
      end
      else
      begin
         bus_open <= 1'b1;
         if (cmd_fire)
         begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b1;
         end
         else
         begin
            if (aw_fire)
            begin
               aw_held <= 1'b1;
            end
            if (w_fire)
            begin
               w_held <= 1'b1;
            end
            if (bvalid && bready)
            begin
               bvalid <= 1'b0;
            end
         end
      end
   end

   a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid);

endmodule

/* design/cmd_fifo.sv */
`timescale 1ns/1ps

module cmd_fifo
   import engine_ctrl_pkg::*;
#(
   parameter type payload_t = logic
)
(
   input  logic     clk,
   input  logic     rst_n,
   input  logic     push_valid,
   input  payload_t push_data,
   output logic     push_ready,
   output logic     pop_valid,
   output payload_t pop_data,
   input  logic     pop_ready
);

   payload_t mem [FIFO_DEPTH];

   logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;   // Depth is a power of two
   logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
   logic [$clog2(FIFO_DEPTH+1)-1:0] count;
   logic                            push_fire;
   logic                            pop_fire;

   assign push_ready = (count != FIFO_DEPTH);
   assign pop_valid  = (count != 0);
   assign pop_data   = mem[rd_ptr];

   assign push_fire = push_valid && push_ready;
   assign pop_fire  = pop_valid && pop_ready;

   always_ff @(posedge clk)
   begin
      if (push_fire)
      begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push_fire)
         begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_fire)
         begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push_fire, pop_fire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

   // A full queue never overwrites its oldest entry
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
      (count == FIFO_DEPTH) && !pop_ready |=> $stable(pop_data) && (count == FIFO_DEPTH));

   // A waiting head entry stays put until it is taken
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
      pop_valid && !pop_ready |=> pop_valid && $stable(pop_data));

endmodule

/* design/engine_ctrl_pkg.sv */
package engine_ctrl_pkg;

   localparam int AXI_ADDR_WIDTH   = 40;
   localparam int DATA_WIDTH       = 32;
   localparam int REG_INDEX_WIDTH  = 14;   // Byte address bits 15:2

   localparam int PIECE_WIDTH      = 4;
   localparam int SIDE_WIDTH       = 8 * PIECE_WIDTH;   // One rank of eight squares
   localparam int BOARD_RANKS      = 8;
   localparam int BOARD_WIDTH      = BOARD_RANKS * SIDE_WIDTH;

   localparam int MOVE_INDEX_WIDTH = 8;
   localparam int EVAL_WIDTH       = 24;
   localparam int HALF_MOVE_WIDTH  = 8;

   localparam int FIFO_DEPTH       = 4;

   // Word indices
   localparam int REG_CONTROL      = 0;
   localparam int REG_MOVE_INDEX   = 1;
   localparam int REG_POSITION     = 2;
   localparam int REG_HALF_MOVE    = 3;
   localparam int REG_BOARD_BASE   = 8;     // Ranks 0..7 follow
   localparam int REG_MOVE_EVAL    = 134;
   localparam int REG_MOVE_COUNT   = 135;

   // Control word bits
   localparam int CTRL_NEW_BOARD_BIT   = 0;
   localparam int CTRL_CLEAR_MOVES_BIT = 1;
   localparam int CTRL_MOVES_READY_BIT = 2;
   localparam int CTRL_MOVE_READY_BIT  = 3;
   localparam int CTRL_IDLE_BIT        = 7;
   localparam int CTRL_SOFT_RESET_BIT  = 31;

   typedef logic [REG_INDEX_WIDTH-1:0] reg_index_t;

   typedef struct packed {
      reg_index_t            index;
      logic [DATA_WIDTH-1:0] data;
   } wr_cmd_t;

endpackage
